// ==== uart_pkg.sv ====
// ==============================
// shared constants and state types for the framed string UART
// import by wildcard in each module header
// ==============================

package uart_pkg;

	// clocking
	localparam int CLK_FREQ     = 50_000_000;
	localparam int BAUD_RATE    = 115_200;
	localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
	localparam int HALF_BIT     = CLKS_PER_BIT / 2;
	// width of the bit-period counters
	localparam int CNT_BITS     = $clog2(CLKS_PER_BIT);

	// line framing
	localparam int TX_STOP_BITS = 2;
	localparam int RX_STOP_BITS = 1;

	// string framing, byte 0 sits in the low bits
	localparam logic [7:0] DELIM_CHAR = 8'h26;
	localparam int MAX_STR_BYTES      = 137;
	localparam int STR_BITS           = MAX_STR_BYTES * 8;
	localparam int LEN_BITS           = 8;

	// serial line states
	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} tx_state_e;

	// receive side walks through the same states
	typedef tx_state_e rx_state_e;

	typedef enum logic [2:0] {
		S_IDLE,
		S_SIGN1,
		S_SIGN2,
		S_CONTENT,
		S_SIGN3,
		S_SIGN4,
		S_FINISH
	} send_state_e;

	typedef enum logic [2:0] {
		P_HUNT1,
		P_HUNT2,
		P_CONTENT,
		P_CLOSE,
		P_FINISH
	} parse_state_e;

endpackage

// ==== uart_tx.sv ====
// ==============================
// byte transmitter, 8N2, LSB first
// pulse tx_req while idle, tx_done follows the last stop bit
// ==============================
`timescale 1ns/1ps

module uart_tx
	import uart_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] tx_data,
	input  logic       tx_req,
	output logic       tx,
	output logic       tx_done
);

	tx_state_e           state;
	logic [CNT_BITS-1:0] clk_cnt;
	logic [2:0]          bit_idx;
	logic [7:0]          shift_reg;
	logic                bit_end;

	assign bit_end = (clk_cnt == CNT_BITS'(CLKS_PER_BIT - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			tx      <= 1'b1;
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			case (state)
				IDLE: begin
					clk_cnt <= '0;
					if (tx_req) begin
						state <= START;
						tx    <= 1'b0;
					end
				end
				START: begin
					if (bit_end) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= DATA;
						tx      <= shift_reg[0];
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				DATA: begin
					if (bit_end) begin
						clk_cnt <= '0;
						if (bit_idx == 3'd7) begin
							bit_idx <= '0;
							state   <= STOP;
							tx      <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							// shift_reg moves on this same edge
							tx      <= shift_reg[1];
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				STOP: begin
					if (bit_end) begin
						clk_cnt <= '0;
						if (bit_idx == 3'(TX_STOP_BITS - 1)) begin
							state   <= IDLE;
							tx_done <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// data byte, shifted right once per data bit
	always_ff @(posedge sys_clk) begin
		if (state == IDLE && tx_req)
			shift_reg <= tx_data;
		else if (state == DATA && bit_end)
			shift_reg <= {1'b0, shift_reg[7:1]};
	end

endmodule

// ==== uart_rx.sv ====
// ==============================
// byte receiver, 8N1, mid-bit sampling
// rx_vld with rx_data on a good stop bit, rx_err on a low one
// ==============================
`timescale 1ns/1ps

module uart_rx
	import uart_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rx,
	output logic [7:0] rx_data,
	output logic       rx_vld,
	output logic       rx_err
);

	rx_state_e           state;
	logic                rx_meta;
	logic                rx_sync;
	logic                rx_prev;
	logic [CNT_BITS-1:0] clk_cnt;
	logic [2:0]          bit_idx;
	logic [7:0]          shift_reg;
	logic                bit_end;
	logic                mid_start;
	logic                start_edge;
	logic                stop_good;

	// two flops into the clock domain, one more for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign start_edge = rx_prev & ~rx_sync;
	assign bit_end    = (clk_cnt == CNT_BITS'(CLKS_PER_BIT - 1));
	assign mid_start  = (clk_cnt == CNT_BITS'(HALF_BIT - 1));
	assign stop_good  = (state == STOP) && bit_end && rx_sync &&
		(bit_idx == 3'(RX_STOP_BITS - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			rx_vld  <= 1'b0;
			rx_err  <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			rx_err <= 1'b0;
			case (state)
				IDLE: begin
					clk_cnt <= '0;
					if (start_edge)
						state <= START;
				end
				START: begin
					if (mid_start) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// a glitch that is high again by now is no start bit
						state   <= rx_sync ? IDLE : DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				DATA: begin
					if (bit_end) begin
						clk_cnt <= '0;
						if (bit_idx == 3'd7) begin
							bit_idx <= '0;
							state   <= STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				STOP: begin
					if (bit_end) begin
						clk_cnt <= '0;
						if (!rx_sync) begin
							rx_err <= 1'b1;
							state  <= IDLE;
						end else if (stop_good) begin
							rx_vld <= 1'b1;
							state  <= IDLE;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// LSB arrives first, so shift in from the top
	always_ff @(posedge sys_clk) begin
		if (state == DATA && bit_end)
			shift_reg <= {rx_sync, shift_reg[7:1]};
		if (stop_good)
			rx_data <= shift_reg;
	end

endmodule

// ==== frame_sender.sv ====
// ==============================
// string sender, wraps the content in "&&" ... "&&"
// pulse tx_req with tx_string and tx_length stable
// ==============================
`timescale 1ns/1ps

module frame_sender
	import uart_pkg::*;
(
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic [STR_BITS-1:0] tx_string,
	input  logic [LEN_BITS-1:0] tx_length,
	input  logic                tx_req,
	input  logic                byte_done,
	output logic [7:0]          byte_data,
	output logic                byte_req,
	output logic                tx_busy,
	output logic                tx_done
);

	send_state_e         state;
	logic [STR_BITS-1:0] str_buf;
	logic [LEN_BITS-1:0] rem_cnt;
	logic                accept;
	logic                issue_delim;
	logic                issue_char;

	assign accept = (state == S_IDLE) && tx_req;

	// which byte goes to the transmitter next
	always_comb begin
		issue_delim = 1'b0;
		issue_char  = 1'b0;
		case (state)
			S_IDLE:
				issue_delim = tx_req;
			S_SIGN1, S_SIGN3:
				issue_delim = byte_done;
			S_SIGN2, S_CONTENT: begin
				if (byte_done) begin
					if (rem_cnt == '0)
						issue_delim = 1'b1;
					else
						issue_char = 1'b1;
				end
			end
			default: begin
				issue_delim = 1'b0;
				issue_char  = 1'b0;
			end
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= S_IDLE;
			rem_cnt  <= '0;
			byte_req <= 1'b0;
		end else begin
			byte_req <= issue_delim | issue_char;
			case (state)
				S_IDLE: begin
					if (tx_req) begin
						state   <= S_SIGN1;
						// longer requests are cut to the buffer size
						rem_cnt <= (tx_length > LEN_BITS'(MAX_STR_BYTES)) ?
							LEN_BITS'(MAX_STR_BYTES) : tx_length;
					end
				end
				S_SIGN1:
					if (byte_done) state <= S_SIGN2;
				S_SIGN2, S_CONTENT: begin
					if (byte_done) begin
						if (rem_cnt == '0) begin
							state <= S_SIGN3;
						end else begin
							state   <= S_CONTENT;
							rem_cnt <= rem_cnt - 1'b1;
						end
					end
				end
				S_SIGN3:
					if (byte_done) state <= S_SIGN4;
				S_SIGN4:
					if (byte_done) state <= S_FINISH;
				S_FINISH:
					state <= S_IDLE;
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// string buffer drains from byte 0 upwards
	always_ff @(posedge sys_clk) begin
		if (accept)
			str_buf <= tx_string;
		else if (issue_char)
			str_buf <= {8'h00, str_buf[STR_BITS-1:8]};
		if (issue_char)
			byte_data <= str_buf[7:0];
		else if (issue_delim)
			byte_data <= DELIM_CHAR;
	end

	assign tx_busy = (state != S_IDLE) && (state != S_FINISH);
	assign tx_done = (state == S_FINISH);

endmodule

// ==== frame_parser.sv ====
// ==============================
// frame parser on received bytes
// hunts "&&", collects content, closes on "&&"
// read rx_string and rx_length when rx_done pulses
// ==============================
`timescale 1ns/1ps

module frame_parser
	import uart_pkg::*;
(
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic [7:0]          rx_data,
	input  logic                rx_vld,
	input  logic                rx_err,
	output logic [STR_BITS-1:0] rx_string,
	output logic [LEN_BITS-1:0] rx_length,
	output logic                rx_busy,
	output logic                rx_done,
	output logic                rx_error
);

	parse_state_e        state;
	logic [STR_BITS-1:0] wr_buf;
	logic [LEN_BITS-1:0] wr_cnt;
	logic                is_delim;
	logic                in_frame;
	logic                open_frame;
	logic                close_frame;
	logic                store_one;
	logic                store_two;
	logic                abort;

	assign is_delim    = (rx_data == DELIM_CHAR);
	assign in_frame    = (state == P_CONTENT) || (state == P_CLOSE);
	assign open_frame  = (state == P_HUNT2) && rx_vld && is_delim;
	assign close_frame = (state == P_CLOSE) && rx_vld && is_delim;
	assign store_one   = (state == P_CONTENT) && rx_vld && !is_delim &&
		(wr_cnt != LEN_BITS'(MAX_STR_BYTES));
	// held '&' plus this byte, needs two free slots
	assign store_two   = (state == P_CLOSE) && rx_vld && !is_delim &&
		(wr_cnt < LEN_BITS'(MAX_STR_BYTES - 1));
	// a content byte that found no room means overflow
	assign abort       = in_frame &&
		(rx_err || (rx_vld && !is_delim && !store_one && !store_two));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= P_HUNT1;
			wr_cnt    <= '0;
			rx_error  <= 1'b0;
			rx_string <= '0;
			rx_length <= '0;
		end else begin
			rx_error <= abort;
			case (state)
				P_HUNT1:
					if (rx_vld && is_delim) state <= P_HUNT2;
				P_HUNT2: begin
					if (open_frame)
						state <= P_CONTENT;
					else if (rx_vld || rx_err)
						state <= P_HUNT1;
				end
				P_CONTENT: begin
					if (abort)
						state <= P_HUNT1;
					else if (rx_vld && is_delim)
						state <= P_CLOSE;
				end
				P_CLOSE: begin
					if (abort)
						state <= P_HUNT1;
					else if (close_frame)
						state <= P_FINISH;
					else if (store_two)
						state <= P_CONTENT;
				end
				P_FINISH:
					state <= P_HUNT1;
				default:
					state <= P_HUNT1;
			endcase

			if (open_frame)
				wr_cnt <= '0;
			else if (store_one)
				wr_cnt <= wr_cnt + 8'd1;
			else if (store_two)
				wr_cnt <= wr_cnt + 8'd2;

			// outputs only move on a complete frame
			if (close_frame) begin
				rx_string <= wr_buf;
				rx_length <= wr_cnt;
			end
		end
	end

	// working buffer, cleared on open so unused bytes read as zero
	always_ff @(posedge sys_clk) begin
		if (open_frame)
			wr_buf <= '0;
		else if (store_one)
			wr_buf[{wr_cnt, 3'b000} +: 8] <= rx_data;
		else if (store_two)
			wr_buf[{wr_cnt, 3'b000} +: 16] <= {rx_data, DELIM_CHAR};
	end

	assign rx_busy = (state == P_HUNT2) || in_frame;
	assign rx_done = (state == P_FINISH);

endmodule

// ==== uart_control.sv ====
// ==============================
// framed string UART top
// sender and transmitter drive uart_tx_port
// receiver and parser listen on uart_rx_port
// ==============================
`timescale 1ns/1ps

module uart_control
	import uart_pkg::*;
(
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic [STR_BITS-1:0] tx_string,
	input  logic [LEN_BITS-1:0] tx_length,
	input  logic                tx_req,
	input  logic                uart_rx_port,
	output logic                tx_busy,
	output logic                tx_done,
	output logic [STR_BITS-1:0] rx_string,
	output logic [LEN_BITS-1:0] rx_length,
	output logic                rx_busy,
	output logic                rx_done,
	output logic                rx_error,
	output logic                uart_tx_port
);

	// byte link, sender to transmitter
	logic [7:0] byte_data;
	logic       byte_req;
	logic       byte_done;

	// byte link, receiver to parser
	logic [7:0] rx_data;
	logic       rx_vld;
	logic       rx_err;

	frame_sender ins_frame_sender (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.byte_done (byte_done),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done)
	);

	uart_tx ins_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_data   (byte_data),
		.tx_req    (byte_req),
		.tx        (uart_tx_port),
		.tx_done   (byte_done)
	);

	uart_rx ins_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld),
		.rx_err    (rx_err)
	);

	frame_parser ins_frame_parser (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld),
		.rx_err    (rx_err),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.rx_error  (rx_error)
	);

endmodule

// ==== uart_control_asserts.sv ====
// ==============================
// protocol assertions on uart_control
// attached to every uart_control by the bind below
// ==============================
`timescale 1ns/1ps

module uart_control_asserts
	import uart_pkg::*;
(
	input logic         sys_clk,
	input logic         sys_rst_n,
	input logic         tx_busy,
	input logic         tx_done,
	input logic         rx_done,
	input logic         rx_error,
	input logic         uart_tx_port,
	input parse_state_e parser_state
);

	int assert_fails = 0;

	tx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_done)
	else begin
		$error("tx_done high for more than one cycle");
		assert_fails++;
	end

	rx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |=> !rx_done)
	else begin
		$error("rx_done high for more than one cycle");
		assert_fails++;
	end

	// line idles high whenever no frame is going out
	tx_line_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_tx_port)
	else begin
		$error("uart_tx_port low while tx_busy is low");
		assert_fails++;
	end

	done_or_error: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(rx_done && rx_error))
	else begin
		$error("rx_done and rx_error in the same cycle");
		assert_fails++;
	end

	parser_legal: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		parser_state inside {P_HUNT1, P_HUNT2, P_CONTENT, P_CLOSE, P_FINISH})
	else begin
		$error("parser FSM in an illegal state");
		assert_fails++;
	end

endmodule

bind uart_control uart_control_asserts u_asserts (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.tx_busy      (tx_busy),
	.tx_done      (tx_done),
	.rx_done      (rx_done),
	.rx_error     (rx_error),
	.uart_tx_port (uart_tx_port),
	.parser_state (ins_frame_parser.state)
);

// ==== tb_uart_control.sv ====
// ==============================
// testbench for uart_control
// table rows run either in loopback or on a bit-banged line
// ==============================
`timescale 1ns/1ps

module tb_uart_control
	import uart_pkg::*;
();

	localparam int MAX_ROWS  = 12;
	localparam int MODE_LOOP = 0;
	localparam int MODE_BUSY = 1;
	localparam int MODE_BANG = 2;
	localparam int MODE_HUNT = 3;

	logic                sys_clk;
	logic                sys_rst_n;
	logic [STR_BITS-1:0] tx_string;
	logic [LEN_BITS-1:0] tx_length;
	logic                tx_req;
	logic                uart_rx_port;
	logic                tx_busy;
	logic                tx_done;
	logic [STR_BITS-1:0] rx_string;
	logic [LEN_BITS-1:0] rx_length;
	logic                rx_busy;
	logic                rx_done;
	logic                rx_error;
	logic                uart_tx_port;
	logic                loop_sel;
	logic                bb_line;

	// stimulus table and expected results
	string               row_name [MAX_ROWS];
	logic [STR_BITS-1:0] row_str [MAX_ROWS];
	int                  row_len [MAX_ROWS];
	int                  row_mode [MAX_ROWS];
	int                  row_bad [MAX_ROWS];
	bit                  row_err [MAX_ROWS];
	logic [STR_BITS-1:0] exp_str [MAX_ROWS];
	int                  exp_len [MAX_ROWS];
	logic [STR_BITS-1:0] last_str;
	int                  last_len;
	int                  n_rows;

	integer seed = 32'h6242;
	int     tx_done_cnt = 0;
	int     rx_done_cnt = 0;
	int     rx_err_cnt = 0;
	int     rx_busy_cyc = 0;
	int     errors;
	int     passed;
	int     failed;
	bit     timed_out;

	uart_control dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.uart_rx_port (uart_rx_port),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_error     (rx_error),
		.uart_tx_port (uart_tx_port)
	);

	// loopback or the bit-banged line
	assign uart_rx_port = loop_sel ? uart_tx_port : bb_line;

	initial sys_clk = 1'b0;
	always #5 sys_clk = ~sys_clk;

	// strobe counters and cycles with rx_busy high
	always @(posedge sys_clk) begin
		if (tx_done)
			tx_done_cnt <= tx_done_cnt + 1;
		if (rx_done)
			rx_done_cnt <= rx_done_cnt + 1;
		if (rx_error)
			rx_err_cnt <= rx_err_cnt + 1;
		if (rx_busy)
			rx_busy_cyc <= rx_busy_cyc + 1;
	end

	function automatic logic [STR_BITS-1:0] pack_text(input string s);
		logic [STR_BITS-1:0] v;
		int i;
		v = '0;
		for (i = 0; i < s.len(); i++)
			v[i*8 +: 8] = s[i];
		return v;
	endfunction

	function automatic logic [STR_BITS-1:0] rand_text(input int n);
		logic [STR_BITS-1:0] v;
		logic [7:0] b;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			b = 8'($random(seed));
			// a random '&' would end the frame early
			if (b == DELIM_CHAR)
				b = 8'h2b;
			v[i*8 +: 8] = b;
		end
		return v;
	endfunction

	task automatic add_row(input string name, input logic [STR_BITS-1:0] str,
		input int len, input int mode, input int bad, input bit err);
		row_name[n_rows] = name;
		row_str[n_rows]  = str;
		row_len[n_rows]  = len;
		row_mode[n_rows] = mode;
		row_bad[n_rows]  = bad;
		row_err[n_rows]  = err;
		// a dropped frame leaves the last good string in place
		if (!err) begin
			last_str = str;
			last_len = (len > MAX_STR_BYTES) ? MAX_STR_BYTES : len;
		end
		exp_str[n_rows] = last_str;
		exp_len[n_rows] = last_len;
		n_rows++;
	endtask

	task automatic build_table();
		add_row("plain", pack_text("hello"), 5, MODE_LOOP, -1, 1'b0);
		add_row("lone delim", pack_text("a&b"), 3, MODE_LOOP, -1, 1'b0);
		add_row("leading delim", pack_text("&x&y"), 4, MODE_LOOP, -1, 1'b0);
		add_row("empty", '0, 0, MODE_LOOP, -1, 1'b0);
		add_row("random full", rand_text(MAX_STR_BYTES), MAX_STR_BYTES, MODE_LOOP, -1, 1'b0);
		add_row("req while busy", rand_text(40), 40, MODE_BUSY, -1, 1'b0);
		add_row("hunt", pack_text("frame"), 5, MODE_HUNT, -1, 1'b0);
		add_row("bad stop", pack_text("broken"), 6, MODE_BANG, 2, 1'b1);
		add_row("overflow", rand_text(MAX_STR_BYTES), MAX_STR_BYTES + 1, MODE_BANG, -1, 1'b1);
		add_row("clamped", rand_text(MAX_STR_BYTES), 200, MODE_LOOP, -1, 1'b0);
	endtask

	task automatic drive_bit(input logic v);
		@(posedge sys_clk);
		bb_line <= v;
		repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
	endtask

	task automatic send_byte(input logic [7:0] b, input bit stop_ok);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < 8; i++)
			drive_bit(b[i]);
		drive_bit(stop_ok);
		// idle bit so the next start edge is seen
		if (!stop_ok)
			drive_bit(1'b1);
	endtask

	task automatic send_frame(input int idx);
		logic [7:0] b;
		int i;
		if (row_mode[idx] == MODE_HUNT) begin
			send_byte(8'h78, 1'b1);
			send_byte(8'h79, 1'b1);
			send_byte(DELIM_CHAR, 1'b1);
			send_byte(8'h7a, 1'b1);
		end
		send_byte(DELIM_CHAR, 1'b1);
		send_byte(DELIM_CHAR, 1'b1);
		for (i = 0; i < row_len[idx]; i++) begin
			b = (i < MAX_STR_BYTES) ? row_str[idx][i*8 +: 8] : 8'h5a;
			send_byte(b, i != row_bad[idx]);
		end
		// the parser hunts again after an abort, so a closing "&&" would open a new frame
		if (!row_err[idx]) begin
			send_byte(DELIM_CHAR, 1'b1);
			send_byte(DELIM_CHAR, 1'b1);
		end
	endtask

	function automatic int count_of(input int sel);
		if (sel == 0)
			return tx_done_cnt;
		else if (sel == 1)
			return rx_done_cnt;
		return rx_err_cnt;
	endfunction

	task automatic wait_event(input int idx, input int sel, input int base, input int limit);
		int t;
		t = 0;
		while (count_of(sel) == base && t < limit) begin
			@(posedge sys_clk);
			t++;
		end
		if (count_of(sel) == base) begin
			$display("test %0d: no %s within %0d cycles", idx,
				(sel == 0) ? "tx_done" : (sel == 1) ? "rx_done" : "rx_error", limit);
			timed_out = 1'b1;
		end
	endtask

	task automatic pulse_while_busy(input int idx);
		int t;
		t = 0;
		while (!tx_busy && t < 100) begin
			@(posedge sys_clk);
			t++;
		end
		if (!tx_busy) begin
			$display("test %0d: tx_busy never rose after tx_req", idx);
			timed_out = 1'b1;
		end else begin
			repeat (CLKS_PER_BIT) @(posedge sys_clk);
			tx_string <= ~row_str[idx];
			tx_length <= 8'd3;
			tx_req    <= 1'b1;
			@(posedge sys_clk);
			tx_req    <= 1'b0;
		end
	endtask

	task automatic expect_val(input string name, input int exp, input int got);
		if (got != exp) begin
			$display("FAILED t=%0t %s expected %0d got %0d", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_row(input int idx, input int done0, input int err0, input int busy0);
		int i;
		int bad;
		expect_val("rx_length", exp_len[idx], int'(rx_length));
		bad = -1;
		for (i = MAX_STR_BYTES - 1; i >= 0; i--)
			if (rx_string[i*8 +: 8] !== exp_str[idx][i*8 +: 8])
				bad = i;
		if (bad >= 0) begin
			$display("FAILED t=%0t rx_string byte %0d expected %h got %h", $time, bad,
				exp_str[idx][bad*8 +: 8], rx_string[bad*8 +: 8]);
			errors++;
		end
		expect_val("rx_done count", row_err[idx] ? 0 : 1, rx_done_cnt - done0);
		expect_val("rx_error count", row_err[idx] ? 1 : 0, rx_err_cnt - err0);
		// every row opens a frame with "&&"
		expect_val("rx_busy seen high", 1, int'(rx_busy_cyc != busy0));
		expect_val("rx_busy", 0, int'(rx_busy));
		expect_val("tx_busy", 0, int'(tx_busy));
	endtask

	task automatic run_row(input int idx);
		int done0;
		int err0;
		int txd0;
		int busy0;
		int errs0;
		int limit;
		done0 = rx_done_cnt;
		err0  = rx_err_cnt;
		txd0  = tx_done_cnt;
		busy0 = rx_busy_cyc;
		errs0 = errors;
		limit = (row_len[idx] + 8) * 11 * CLKS_PER_BIT;
		@(posedge sys_clk);
		if (row_mode[idx] == MODE_LOOP || row_mode[idx] == MODE_BUSY) begin
			loop_sel  <= 1'b1;
			tx_string <= row_str[idx];
			tx_length <= LEN_BITS'(row_len[idx]);
			tx_req    <= 1'b1;
			@(posedge sys_clk);
			tx_req    <= 1'b0;
			if (row_mode[idx] == MODE_BUSY)
				pulse_while_busy(idx);
			if (!timed_out)
				wait_event(idx, 0, txd0, limit);
		end else begin
			loop_sel <= 1'b0;
			send_frame(idx);
		end
		if (!timed_out)
			wait_event(idx, row_err[idx] ? 2 : 1, row_err[idx] ? err0 : done0, limit);
		if (!timed_out) begin
			// wait so a late strobe or a second frame shows in the counts
			repeat (2 * CLKS_PER_BIT) @(posedge sys_clk);
			check_row(idx, done0, err0, busy0);
		end
		if (errors == errs0 && !timed_out) begin
			$display("test %0d %s: ok", idx, row_name[idx]);
			passed++;
		end else begin
			$display("test %0d %s: did not match", idx, row_name[idx]);
			failed++;
		end
	endtask

	task automatic check_reset();
		int errs0;
		errs0 = errors;
		expect_val("tx_busy", 0, int'(tx_busy));
		expect_val("tx_done", 0, int'(tx_done));
		expect_val("rx_busy", 0, int'(rx_busy));
		expect_val("rx_done", 0, int'(rx_done));
		expect_val("rx_error", 0, int'(rx_error));
		expect_val("uart_tx_port", 1, int'(uart_tx_port));
		expect_val("rx_length", 0, int'(rx_length));
		if (rx_string !== '0) begin
			$display("FAILED t=%0t rx_string expected 0 got nonzero", $time);
			errors++;
		end
		if (errors == errs0) begin
			$display("test reset: ok");
			passed++;
		end else begin
			$display("test reset: did not match");
			failed++;
		end
	endtask

	initial begin
		int r;
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req    = 1'b0;
		loop_sel  = 1'b1;
		bb_line   = 1'b1;
		n_rows    = 0;
		last_str  = '0;
		last_len  = 0;
		errors    = 0;
		passed    = 0;
		failed    = 0;
		timed_out = 1'b0;
		build_table();
		repeat (8) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(posedge sys_clk);
		check_reset();
		for (r = 0; r < n_rows; r++)
			if (!timed_out)
				run_row(r);
		$display("%0d tests passed, %0d failed, %0d check errors, %0d assertion errors",
			passed, failed, errors, dut.u_asserts.assert_fails);
		if (errors == 0 && failed == 0 && !timed_out && dut.u_asserts.assert_fails == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== files.f ====
uart_pkg.sv
uart_tx.sv
uart_rx.sv
frame_sender.sv
frame_parser.sv
uart_control.sv
uart_control_asserts.sv
tb_uart_control.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_uart_control
FILELIST  := files.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
PASS_MSG  := test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
